//--- verilog/icache_cfg.svh
// Build-time configuration of the instruction cache miss path
// Core and channel numbering, snoop back-off and line geometry
// Nothing here can be changed at run time
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// Core number placed in the upper field of every transaction id
`define ICACHE_CORENO	6'd1

// Bus channel of this cache, also used to ignore our own snoops
`define ICACHE_CID	6'd0

// Minimum number of back-off cycles after a burst or an abort
`define ICACHE_WAIT	6'd6

// Virtual address width in bits
`define ICACHE_ADR_W	32

// A line is 64 bytes, so the line address starts at bit 6
`define ICACHE_TAG_LO	6
// Top cache index bit, 256 sets of 64 bytes
`define ICACHE_IDX_HI	13

// One bus beat carries a quarter line of 128 bits
`define ICACHE_QTR_W	128

`endif

//--- verilog/bus_pkg.sv
// Tagged split-transaction bus definitions
// Command and transfer-type encodings
// Transaction id layout, request and response bundles
`include "icache_cfg.svh"

package bus_pkg;

	// ==============================
	// Encodings
	// ==============================

	// Bus commands, only the instruction fetch is issued here
	typedef enum logic [4:0] {
		CMD_NONE = 5'd0,
		CMD_LOAD = 5'd2,
		CMD_STORE = 5'd3,
		CMD_ICACHE_LOAD = 5'd8
	} bus_cmd_t;

	// Cycle type identifier, a burst ends with EOB on its last beat
	typedef enum logic [2:0] {
		CLASSIC = 3'd0,
		FIXED = 3'd1,
		INCR = 3'd2,
		EOB = 3'd7
	} bus_cti_t;

	// ==============================
	// Bundles
	// ==============================

	// Transaction id, unique per core and channel
	typedef struct packed {
		logic [5:0] core;
		logic [5:0] channel;
		logic [3:0] tranid;
	} bus_tid_t;

	// Request from a master, cyc and stb are levels held until accepted
	typedef struct packed {
		bus_cmd_t cmd;
		bus_cti_t cti;
		bus_tid_t tid;
		logic [7:0] asid;
		logic cyc;
		logic stb;
		logic [15:0] sel;
		logic we;
		logic [`ICACHE_ADR_W-1:0] vadr;
	} bus_req_t;

	// Response, valid for exactly the cycles where ack is high
	typedef struct packed {
		logic ack;
		bus_tid_t tid;
		logic [`ICACHE_QTR_W-1:0] dat;
	} bus_resp_t;

endpackage

//--- verilog/icache_pkg.sv
// Instruction cache types
// Address, address space, transaction counter and line data
// Request generator state encoding
`include "icache_cfg.svh"

package icache_pkg;

	// Virtual byte address
	typedef logic [`ICACHE_ADR_W-1:0] address_t;

	// Address space id sent along with each request
	typedef logic [7:0] asid_t;

	// Transaction counter, wraps modulo 16
	typedef logic [3:0] tranid_t;

	// One bus beat of line data
	typedef logic [`ICACHE_QTR_W-1:0] quarter_t;

	// A full line is four quarters, quarter 0 in the low bits
	typedef quarter_t [3:0] line_t;

	// Miss request generator states
	typedef enum logic [2:0] {
		REQ_RESET,
		REQ_IDLE,
		REQ_ISSUE,
		REQ_GAP,
		REQ_BACKOFF
	} req_state_t;

endpackage

//--- verilog/lfsr17.sv
// 17-bit maximal-length Fibonacci LFSR
// Supplies pseudo-random bits for the miss back-off
`timescale 1ns/10ps

module lfsr17
(
	input logic clk,
	input logic rst,
	input logic ce,
	output logic [16:0] o
);

	logic fb;

	// Taps at bits 17 and 14 give the full 2^17-1 sequence
	assign fb = o[16] ^ o[13];

	always_ff @(posedge clk, posedge rst)
	begin
		// Any non-zero seed works, all zeros would lock up
		if (rst)
			o <= 17'h00001;
		else if (ce)
			o <= {o[15:0], fb};
	end

endmodule

//--- verilog/icache_req_generator.sv
// Instruction cache miss request generator
// Turns a miss into a burst of four quarter-line reads
// Records the address of each request under its transaction id
// Holds on bus back-pressure, backs off randomly after each burst
// Aborts a burst when another channel snoops the same cache index
`timescale 1ns/10ps
`include "icache_cfg.svh"

module icache_req_generator
(
	input logic clk,
	input logic rst,
	input logic hit,
	input icache_pkg::address_t miss_adr,
	input icache_pkg::asid_t miss_asid,
	input logic full,
	input logic snoop_v,
	input icache_pkg::address_t snoop_adr,
	input logic [5:0] snoop_cid,
	input logic [16:0] lfsr_o,
	output bus_pkg::bus_req_t req,
	output icache_pkg::address_t [15:0] vtags,
	output icache_pkg::req_state_t state
);

	import bus_pkg::*;
	import icache_pkg::*;

	// Line-aligned address of the burst in progress
	address_t madr;
	// Aligned form of the incoming miss address
	address_t line_adr;
	// Address of the quarter about to be presented
	address_t qtr_adr;
	// Address written into the tag record
	address_t vt_adr;
	tranid_t tid_cnt;
	// Quarter being presented, 0 to 3
	logic [1:0] qcnt;
	logic [7:0] rst_cnt;
	logic [5:0] wait_cnt;
	logic accept;
	logic snoop_hit;
	logic vt_we;

	// ==============================
	// Request building
	// ==============================

	// Idle bus level, the command field stays valid
	function automatic bus_req_t idle_req();
		bus_req_t r;
		r = '0;
		r.cmd = CMD_ICACHE_LOAD;
		r.cti = CLASSIC;
		return r;
	endfunction

	// A single quarter read with cyc and stb raised
	function automatic bus_req_t quarter_req(address_t adr, bus_cti_t cti,
		asid_t asid, tranid_t tid);
		bus_req_t r;
		r = idle_req();
		r.cti = cti;
		r.tid.core = `ICACHE_CORENO;
		r.tid.channel = `ICACHE_CID;
		r.tid.tranid = tid;
		r.asid = asid;
		r.cyc = 1'b1;
		r.stb = 1'b1;
		r.sel = 16'hFFFF;
		r.vadr = adr;
		return r;
	endfunction

	assign line_adr = {miss_adr[`ICACHE_ADR_W-1:`ICACHE_TAG_LO], {`ICACHE_TAG_LO{1'b0}}};

	// Quarter offset is 16 bytes, two bits of quarter fill bits 5:4
	assign qtr_adr = {madr[`ICACHE_ADR_W-1:`ICACHE_TAG_LO], qcnt, 4'h0};

	// The bus takes a request on any cycle with cyc and stb up and full low
	assign accept = req.cyc & req.stb & ~full;

	// Only the cache index is compared for a snoop hit
	// A snoop only matters while a burst is actually running
	assign snoop_hit = snoop_v && (snoop_cid != `ICACHE_CID)
		&& (snoop_adr[`ICACHE_IDX_HI:`ICACHE_TAG_LO] == madr[`ICACHE_IDX_HI:`ICACHE_TAG_LO])
		&& (state == REQ_ISSUE || state == REQ_GAP);

	// ==============================
	// Tag record
	// ==============================

	// The record is written whenever a quarter is first put on the bus
	assign vt_we = (state == REQ_IDLE && !hit) || (state == REQ_GAP && !snoop_hit);
	assign vt_adr = (state == REQ_IDLE) ? line_adr : qtr_adr;

	always_ff @(posedge clk)
	begin
		if (vt_we)
			vtags[tid_cnt] <= vt_adr;
	end

	// ==============================
	// Burst state machine
	// ==============================

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			state <= REQ_RESET;
			req <= '0;
			madr <= '0;
			tid_cnt <= '0;
			qcnt <= '0;
			rst_cnt <= '0;
			wait_cnt <= '0;
		end
		else
		begin
			// Transaction ids advance once per accepted request
			if (accept)
				tid_cnt <= tid_cnt + 4'd1;
			case (state)
			// Channels leave reset staggered by their id
			REQ_RESET:
			begin
				req <= idle_req();
				if (rst_cnt == {`ICACHE_CID, 2'b00})
					state <= REQ_IDLE;
				rst_cnt <= rst_cnt + 8'd1;
			end
			// First quarter goes out the cycle after the miss is seen
			REQ_IDLE:
				if (!hit)
				begin
					madr <= line_adr;
					qcnt <= 2'd0;
					req <= quarter_req(line_adr, FIXED, miss_asid, tid_cnt);
					state <= REQ_ISSUE;
				end
				else
					req <= idle_req();
			// Request is held unchanged until full drops
			REQ_ISSUE:
				if (!full)
				begin
					if (qcnt == 2'd3)
					begin
						req <= idle_req();
						wait_cnt <= '0;
						state <= REQ_BACKOFF;
					end
					else
					begin
						// cyc drops for one cycle between quarters
						req.cyc <= 1'b0;
						qcnt <= qcnt + 2'd1;
						state <= REQ_GAP;
					end
				end
			// Next quarter, the last one is marked end of burst
			REQ_GAP:
			begin
				req <= quarter_req(qtr_adr, (qcnt == 2'd3) ? EOB : FIXED,
					req.asid, tid_cnt);
				state <= REQ_ISSUE;
			end
			// Count out the minimum wait, then leave on a random LFSR pattern
			REQ_BACKOFF:
			begin
				req <= idle_req();
				if (wait_cnt == `ICACHE_WAIT && lfsr_o[2:0] == 3'b111)
					state <= REQ_IDLE;
				else if (wait_cnt != `ICACHE_WAIT)
					wait_cnt <= wait_cnt + 6'd1;
			end
			default:
				state <= REQ_RESET;
			endcase
			// A matching foreign snoop overrides whatever the burst was doing
			if (snoop_hit)
			begin
				req <= idle_req();
				wait_cnt <= '0;
				state <= REQ_BACKOFF;
			end
		end
	end

endmodule

//--- verilog/icache_fill_collector.sv
// Instruction cache fill collector
// Matches bus responses to recorded request addresses by tranid
// Assembles four quarters into a line buffer
// Emits a one-cycle fill strobe with the completed line
`timescale 1ns/10ps
`include "icache_cfg.svh"

module icache_fill_collector
(
	input logic clk,
	input logic rst,
	input bus_pkg::bus_resp_t resp,
	input icache_pkg::address_t [15:0] vtags,
	output logic fill_v,
	output icache_pkg::address_t fill_line_adr,
	output icache_pkg::line_t fill_line
);

	import icache_pkg::*;

	// Address that was requested under the response's tranid
	address_t r_adr;
	// Aligned line address of that request
	address_t r_line;
	// Line currently being gathered
	address_t buf_adr;
	quarter_t r_dat;
	logic [1:0] slot;
	// One bit per quarter that has arrived
	logic [3:0] mask;
	logic [3:0] mask_nxt;
	logic line_done;
	line_t line_buf;
	line_t line_nxt;

	// ==============================
	// Response decode
	// ==============================

	assign r_adr = vtags[resp.tid.tranid];
	assign r_dat = resp.dat;

	// Bits 5:4 of the byte address pick the quarter within the line
	assign slot = r_adr[5:4];
	assign r_line = {r_adr[`ICACHE_ADR_W-1:`ICACHE_TAG_LO], {`ICACHE_TAG_LO{1'b0}}};

	always_comb
	begin
		line_nxt = line_buf;
		line_nxt[slot] = r_dat;
		// A quarter of some other line starts the buffer over
		if (r_line != buf_adr)
			mask_nxt = 4'b0001 << slot;
		else
			mask_nxt = mask | (4'b0001 << slot);
	end

	// Responses may arrive in any order, the line is whole once all bits are set
	assign line_done = resp.ack && (mask_nxt == 4'hF);

	// ==============================
	// Arrival tracking
	// ==============================

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			buf_adr <= '0;
			mask <= '0;
			fill_v <= 1'b0;
		end
		else
		begin
			fill_v <= line_done;
			if (resp.ack)
			begin
				buf_adr <= r_line;
				if (line_done)
					mask <= '0;
				else
					mask <= mask_nxt;
			end
		end
	end

	// Line data and the completed line
	always_ff @(posedge clk)
	begin
		if (resp.ack)
			line_buf <= line_nxt;
		if (line_done)
		begin
			fill_line <= line_nxt;
			fill_line_adr <= r_line;
		end
	end

endmodule

//--- verilog/icache_miss_top.sv
// Instruction cache miss path top level
// Back-off LFSR, miss request generator and fill collector
`timescale 1ns/10ps

module icache_miss_top
(
	input logic clk,
	input logic rst,
	input logic hit,
	input icache_pkg::address_t miss_adr,
	input icache_pkg::asid_t miss_asid,
	input logic snoop_v,
	input icache_pkg::address_t snoop_adr,
	input logic [5:0] snoop_cid,
	input logic full,
	output bus_pkg::bus_req_t req,
	input bus_pkg::bus_resp_t resp,
	output logic fill_v,
	output icache_pkg::address_t fill_line_adr,
	output icache_pkg::line_t fill_line
);

	import icache_pkg::*;

	// Random bits for the back-off exit
	logic [16:0] lfsr_o;
	// Request addresses indexed by transaction id
	address_t [15:0] vtags;
	// Generator state, the LFSR only runs once reset staggering is over
	req_state_t gen_state;

	lfsr17 i_lfsr
	(
		.clk(clk),
		.rst(rst),
		.ce(gen_state != REQ_RESET),
		.o(lfsr_o)
	);

	icache_req_generator i_gen
	(
		.clk(clk),
		.rst(rst),
		.hit(hit),
		.miss_adr(miss_adr),
		.miss_asid(miss_asid),
		.full(full),
		.snoop_v(snoop_v),
		.snoop_adr(snoop_adr),
		.snoop_cid(snoop_cid),
		.lfsr_o(lfsr_o),
		.req(req),
		.vtags(vtags),
		.state(gen_state)
	);

	icache_fill_collector i_fill
	(
		.clk(clk),
		.rst(rst),
		.resp(resp),
		.vtags(vtags),
		.fill_v(fill_v),
		.fill_line_adr(fill_line_adr),
		.fill_line(fill_line)
	);

endmodule

//--- tb/tb_icache_miss.sv
// Testbench for the instruction cache miss path
// Trace-driven stimulus of misses, snoops and back-pressure windows
// Memory model with random return delay and out-of-order responses
// Request checker, back-pressure checker and fill checker
`timescale 1ns/10ps
`include "icache_cfg.svh"

module tb_icache_miss;

	import bus_pkg::*;
	import icache_pkg::*;

	logic clk;
	logic rst;
	logic hit;
	address_t miss_adr;
	asid_t miss_asid;
	logic snoop_v;
	address_t snoop_adr;
	logic [5:0] snoop_cid;
	logic full;
	bus_req_t req;
	bus_resp_t resp;
	logic fill_v;
	address_t fill_line_adr;
	line_t fill_line;

	// Trace commands as loaded before the run starts
	byte cmd_kind[64];
	int unsigned arg_a[64];
	int unsigned arg_b[64];
	int n_cmds;
	int limit;
	int cycle;
	int errors;
	int checks;
	integer seed;

	// The burst currently expected on the bus
	address_t cur_line;
	asid_t cur_asid;
	int cur_acc;
	int cur_fills;
	bit cur_abort;
	bit cur_active;
	tranid_t exp_tid;
	int tot_acc;
	int tot_fill;

	// Pending responses of the memory model
	int q_due[$];
	tranid_t q_tid[$];
	address_t q_adr[$];
	int found;
	int unsigned delay;

	bus_req_t prev_req;
	bit prev_hold;
	bit prev_rst;
	quarter_t exp_q;
	address_t exp_adr;

	icache_miss_top i_dut
	(
		.clk(clk),
		.rst(rst),
		.hit(hit),
		.miss_adr(miss_adr),
		.miss_asid(miss_asid),
		.snoop_v(snoop_v),
		.snoop_adr(snoop_adr),
		.snoop_cid(snoop_cid),
		.full(full),
		.req(req),
		.resp(resp),
		.fill_v(fill_v),
		.fill_line_adr(fill_line_adr),
		.fill_line(fill_line)
	);

	// ==============================
	// Clock, cycle count, reporting
	// ==============================

	always #50 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	task fail_value(input string name, input logic [127:0] exp, input logic [127:0] act);
		errors++;
		$display("FAILED %s expected %h actual %h", name, exp, act);
	endtask

	task report_error(input string msg);
		errors++;
		$display("Error at cycle %0d: %s", cycle, msg);
	endtask

	task next_cycle();
		@(posedge clk);
		#1;
	endtask

	// ==============================
	// Request and fill monitor
	// ==============================

	// Sampled at the falling edge, where inputs and DUT outputs are stable
	always @(negedge clk)
	begin
		if (rst || prev_rst)
		begin
			checks++;
			if (req.cyc || req.stb || fill_v)
				report_error("bus request or fill active during reset");
		end
		else
		begin
			// Held request under back-pressure must not change at all
			if (prev_hold && req != prev_req)
				report_error("request changed while full was high");
			// A request is taken at the next rising edge
			if (req.cyc && req.stb && !full)
			begin
				checks++;
				exp_adr = cur_line + 32'(cur_acc * 16);
				if (!cur_active || cur_acc > 3)
					report_error("request accepted with no quarter outstanding");
				if (req.vadr != exp_adr)
					fail_value("burst_address", exp_adr, req.vadr);
				if (req.cti != ((cur_acc == 3) ? EOB : FIXED))
					fail_value("burst_cti", (cur_acc == 3) ? EOB : FIXED, req.cti);
				if (req.sel != 16'hFFFF)
					fail_value("burst_sel", 16'hFFFF, req.sel);
				if (req.cmd != CMD_ICACHE_LOAD)
					fail_value("burst_cmd", CMD_ICACHE_LOAD, req.cmd);
				if (req.we != 1'b0)
					fail_value("burst_we", 1'b0, req.we);
				if (req.asid != cur_asid)
					fail_value("burst_asid", cur_asid, req.asid);
				if (req.tid.tranid != exp_tid)
					fail_value("tranid", exp_tid, req.tid.tranid);
				if (req.tid.core != `ICACHE_CORENO)
					fail_value("tid_core", `ICACHE_CORENO, req.tid.core);
				if (req.tid.channel != `ICACHE_CID)
					fail_value("tid_channel", `ICACHE_CID, req.tid.channel);
				// Return delay of 3 to 6 cycles after the accepting edge
				delay = {$random(seed)} % 4;
				q_due.push_back(cycle + 4 + int'(delay));
				q_tid.push_back(req.tid.tranid);
				q_adr.push_back(req.vadr);
				exp_tid = exp_tid + 4'd1;
				cur_acc++;
				tot_acc++;
			end
			if (fill_v)
			begin
				checks++;
				if (cur_abort || cur_acc != 4 || cur_fills != 0)
					report_error("fill without a single completed burst");
				if (fill_line_adr != cur_line)
					fail_value("fill_address", cur_line, fill_line_adr);
				for (int q = 0; q < 4; q++)
				begin
					exp_q = {4{cur_line + 32'(q * 16)}};
					if (fill_line[q] != exp_q)
						fail_value("fill_data", exp_q, fill_line[q]);
				end
				cur_fills++;
				tot_fill++;
			end
		end
		prev_hold = full && req.cyc && req.stb;
		prev_req = req;
		prev_rst = rst;
	end

	// ==============================
	// Memory model
	// ==============================

	// One response per cycle with the oldest due entry first
	always @(posedge clk)
	begin
		#1;
		found = -1;
		for (int i = 0; i < q_due.size(); i++)
			if (found < 0 && q_due[i] <= cycle)
				found = i;
		if (found >= 0)
		begin
			resp.ack = 1'b1;
			resp.tid.core = `ICACHE_CORENO;
			resp.tid.channel = `ICACHE_CID;
			resp.tid.tranid = q_tid[found];
			resp.dat = {4{q_adr[found]}};
			q_due.delete(found);
			q_tid.delete(found);
			q_adr.delete(found);
		end
		else
			resp = '0;
	end

	// ==============================
	// Trace commands
	// ==============================

	// Lets the current burst finish or, once aborted, drain its responses
	task settle_burst();
		int n;
		if (cur_active)
		begin
			n = 0;
			if (cur_abort)
			begin
				// Quarters taken before the abort still get their responses
				while (q_due.size() != 0 && n < 80)
				begin
					next_cycle();
					n++;
				end
				next_cycle();
				if (q_due.size() != 0)
					report_error("responses of the aborted burst never returned");
				if (cur_acc >= 4)
					report_error("aborted burst still sent all four requests");
			end
			else
			begin
				while (cur_fills == 0 && n < 80)
				begin
					next_cycle();
					n++;
				end
				repeat (4) next_cycle();
				checks++;
				if (cur_acc != 4)
					fail_value("burst_length", 4, cur_acc);
				if (cur_fills != 1)
					fail_value("fill_count", 1, cur_fills);
			end
			cur_active = 0;
		end
	endtask

	// Holds hit low until the first quarter is on the bus
	task issue_miss(input address_t adr, input asid_t asid);
		settle_burst();
		cur_line = {adr[`ICACHE_ADR_W-1:6], 6'd0};
		cur_asid = asid;
		cur_acc = 0;
		cur_fills = 0;
		cur_abort = 0;
		cur_active = 1;
		hit = 1'b0;
		miss_adr = adr;
		miss_asid = asid;
		do
			next_cycle();
		while (!req.stb);
		hit = 1'b1;
	endtask

	task pulse_snoop(input address_t adr, input logic [5:0] cid);
		bit abort;
		abort = cur_active && cur_acc < 4 && cid != `ICACHE_CID
			&& adr[13:6] == cur_line[13:6];
		snoop_v = 1'b1;
		snoop_adr = adr;
		snoop_cid = cid;
		next_cycle();
		snoop_v = 1'b0;
		if (abort)
		begin
			cur_abort = 1;
			checks++;
			if (req.cyc || req.stb)
				report_error("matching snoop did not clear the request");
		end
	endtask

	task hold_full(input int n);
		full = 1'b1;
		repeat (n) next_cycle();
		full = 1'b0;
	endtask

	task check_totals(input int acc, input int fills);
		settle_burst();
		repeat (10) next_cycle();
		checks++;
		if (tot_acc != acc)
			fail_value("total_requests", acc, tot_acc);
		if (tot_fill != fills)
			fail_value("total_fills", fills, tot_fill);
	endtask

	task load_trace();
		int fd;
		int r;
		logic [8*100-1:0] text;
		logic [15:0] cmd;
		fd = $fopen("tb/icache_miss_trace.txt", "r");
		if (fd == 0)
			report_error("trace file could not be opened");
		else
		begin
			while (!$feof(fd) && n_cmds < 64)
			begin
				text = '0;
				r = $fgets(text, fd);
				cmd = '0;
				if (r > 0 && $sscanf(text, "%s", cmd) == 1 && cmd != "#")
				begin
					cmd_kind[n_cmds] = cmd[7:0];
					arg_a[n_cmds] = 0;
					arg_b[n_cmds] = 0;
					if (cmd == "F" || cmd == "E")
						r = $sscanf(text, "%s %d %d", cmd, arg_a[n_cmds], arg_b[n_cmds]);
					else
						r = $sscanf(text, "%s %h %h", cmd, arg_a[n_cmds], arg_b[n_cmds]);
					n_cmds++;
				end
			end
			$fclose(fd);
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		hit = 1'b1;
		miss_adr = '0;
		miss_asid = '0;
		snoop_v = 1'b0;
		snoop_adr = '0;
		snoop_cid = '0;
		full = 1'b0;
		resp = '0;
		cycle = 0;
		errors = 0;
		checks = 0;
		seed = 32'hcdd6;
		exp_tid = '0;
		tot_acc = 0;
		tot_fill = 0;
		cur_active = 0;
		cur_abort = 0;
		cur_acc = 0;
		cur_fills = 0;
		prev_hold = 0;
		prev_rst = 1;
		n_cmds = 0;
		limit = 0;
		load_trace();
		limit = 400 * (n_cmds + 1);
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < n_cmds; i++)
		begin
			case (cmd_kind[i])
			"M": issue_miss(arg_a[i], arg_b[i][7:0]);
			"S": pulse_snoop(arg_a[i], arg_b[i][5:0]);
			"F": hold_full(arg_a[i]);
			"E": check_totals(arg_a[i], arg_b[i]);
			default: report_error("unknown trace command");
			endcase
		end
		settle_burst();
		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Ends a hung run once the cycle budget for the trace is spent
	initial
	begin
		wait (limit > 0);
		while (cycle < limit)
			@(posedge clk);
		$display("Timeout: run did not finish within %0d cycles, %0d errors so far",
			limit, errors);
		$display("Errors found");
		$finish;
	end

endmodule

//--- list.f
+incdir+verilog
verilog/bus_pkg.sv
verilog/icache_pkg.sv
verilog/lfsr17.sv
verilog/icache_req_generator.sv
verilog/icache_fill_collector.sv
verilog/icache_miss_top.sv
tb/tb_icache_miss.sv

//--- Makefile
# Verilator simulation of the instruction cache miss path

TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_icache_miss
FILELIST = list.f
PASS     = No errors

.PHONY: sim clean

# The run passes only if the exact pass line shows up in the output
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS)"

clean:
	rm -rf obj_dir

//--- tb/icache_miss_trace.txt
# Columns: M hex-address hex-asid | S hex-address hex-cid | F decimal-cycles
# E decimal-accepted-requests decimal-fills (expected totals at the end)
M 00001040 05
M 00002000 11
F 5
M 00003080 22
S 0000b080 02
M 00004000 33
S 00004000 00
M 00005040 44
S 00005240 03
M 00006ff0 55
F 3
M 000070c0 66
F 8
M 00008100 77
M 0000a000 08
S 0001a000 03
M 0000c0c0 09
F 2
M 0000e000 0a
E 38 9
